/* list.f */
+incdir+dv
source/x86_pkg.sv
source/decode_pipe_pkg.sv
source/prefix_scan.sv
source/opcode_lookup.sv
source/length_calc.sv
source/decode_top.sv
dv/tb_decode_top.sv

/* run.sh */
#!/bin/sh
# Build and run the decode pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_decode_top \
  -f list.f --Mdir obj_dir -o sim_decode
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

/* dv/decode_ref.svh */
//**********************************************************
// Reference decode model used by the scoreboard
//**********************************************************
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Little endian field where a single byte sign extends
function automatic x86_pkg::word_t field_le(input decode_pipe_pkg::fetch_t f,
                                            input int pos, input int n);
  x86_pkg::word_t v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    if (pos + k < 16) begin
      v[8*k +: 8] = f.window[pos+k];
    end
  end
  if (n == 1) begin
    v = {{24{v[7]}}, v[7:0]};
  end
  return v;
endfunction

function automatic x86_pkg::seg_t seg_code(input x86_pkg::byte_t b);
  case (b)
    8'h26:   return 3'd0;
    8'h2E:   return 3'd1;
    8'h36:   return 3'd2;
    8'h3E:   return 3'd3;
    8'h64:   return 3'd4;
    default: return 3'd5;
  endcase
endfunction

function automatic decode_pipe_pkg::decoded_t decode_ref(input decode_pipe_pkg::fetch_t f);
  decode_pipe_pkg::decoded_t d;
  x86_pkg::byte_t            op;
  int                        n;
  int                        pos;
  int                        disp_len;
  int                        imm_len;
  logic                      legal;
  logic                      more;
  d        = '0;
  n        = 0;
  disp_len = 0;
  imm_len  = 0;
  more     = 1'b1;
  for (int i = 0; i < x86_pkg::MAX_PREFIX; i++) begin
    if (more) begin
      case (f.window[i])
        x86_pkg::PFX_REPNE:  d.repne = 1'b1;
        x86_pkg::PFX_OPSIZE: d.opsize16 = 1'b1;
        x86_pkg::PFX_ESC:    d.esc = 1'b1;
        x86_pkg::PFX_ES, x86_pkg::PFX_CS, x86_pkg::PFX_SS,
        x86_pkg::PFX_DS, x86_pkg::PFX_FS, x86_pkg::PFX_GS: begin
          d.seg_over = 1'b1;
          d.seg      = seg_code(f.window[i]);
        end
        default: more = 1'b0;
      endcase
      if (more) begin
        n++;
      end
    end
  end
  op  = f.window[n];
  pos = n + 1;
  if (d.esc) begin
    legal      = (op == 8'hAF);
    d.modrm_pr = legal;
  end else if (op == 8'h01 || op == 8'h89 || op == 8'h83) begin
    legal      = 1'b1;
    d.modrm_pr = 1'b1;
    imm_len    = (op == 8'h83) ? 1 : 0;
  end else if (op == 8'h05 || op == 8'hE8 || op[7:3] == 5'b10111) begin
    legal   = 1'b1;
    imm_len = d.opsize16 ? 2 : 4;
  end else if (op == 8'hEB) begin
    legal   = 1'b1;
    imm_len = 1;
  end else begin
    legal = (op == 8'h90 || op == 8'hC3 || op == 8'hCF || op == 8'hF4);
  end
  if (d.modrm_pr) begin
    d.modrm = f.window[pos];
    pos++;
    d.sib_pr = (d.modrm[7:6] != 2'b11) && (d.modrm[2:0] == 3'b100);
    if (d.sib_pr) begin
      d.sib = f.window[pos];
      pos++;
    end
    case (d.modrm[7:6])
      2'b00: begin
        if (d.modrm[2:0] == 3'b101 || (d.sib_pr && d.sib[2:0] == 3'b101)) begin
          disp_len = 4;
        end
      end
      2'b01:   disp_len = 1;
      2'b10:   disp_len = 4;
      default: disp_len = 0;
    endcase
  end
  d.disp = field_le(f, pos, disp_len);
  pos += disp_len;
  d.imm = field_le(f, pos, imm_len);
  pos += imm_len;
  d.opcode   = op;
  d.len      = x86_pkg::len_t'(pos);
  d.eip      = f.eip;
  d.eip_next = f.eip + x86_pkg::eip_t'(pos);
  d.hlt      = !d.esc && op == 8'hF4;
  d.iret     = !d.esc && op == 8'hCF;
  d.illegal  = !legal;
  return d;
endfunction

`endif

/* dv/tb_decode_top.sv */
//**********************************************************
// Testbench for decode_top with a scoreboard queue
// Directed, random and back-pressure traffic
//**********************************************************
module tb_decode_top;
  timeunit 1ns;
  timeprecision 1ps;

  `include "decode_ref.svh"

  localparam int SEND_LIMIT  = 1000;
  localparam int DRAIN_LIMIT = 2000;

  localparam x86_pkg::byte_t PLAIN_OPS [10] = '{8'h01, 8'h05, 8'h83, 8'h89, 8'h90,
                                                8'hC3, 8'hCF, 8'hE8, 8'hEB, 8'hF4};
  localparam x86_pkg::byte_t MODRM_OPS [3] = '{8'h01, 8'h89, 8'h83};
  localparam x86_pkg::byte_t PREFIX_BYTES [9] = '{
    x86_pkg::PFX_REPNE, x86_pkg::PFX_CS, x86_pkg::PFX_SS, x86_pkg::PFX_DS, x86_pkg::PFX_ES,
    x86_pkg::PFX_FS, x86_pkg::PFX_GS, x86_pkg::PFX_OPSIZE, x86_pkg::PFX_ESC};

  logic                      clk;
  logic                      rst;
  logic                      in_valid;
  logic                      in_ready;
  decode_pipe_pkg::fetch_t   in_data;
  logic                      out_valid;
  logic                      out_ready;
  decode_pipe_pkg::decoded_t out_data;

  decode_pipe_pkg::decoded_t exp_q[$];
  int unsigned               acc_q[$];
  int unsigned               cycle;
  x86_pkg::byte_t [15:0]     win_buf;
  string                     cur_test;
  int                        checks;
  int                        errors;
  int                        test_start_errors;
  int                        tests;
  int                        items;
  logic                      bp_mode;
  logic                      stall_mode;
  logic                      lat_mode;

  decode_top i_decode_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Random stalls in the back-pressure test and a full stop before the mid-run reset
  always @(posedge clk) begin
    if (bp_mode) begin
      out_ready <= ($urandom % 3) != 0;
    end else if (stall_mode) begin
      out_ready <= 1'b0;
    end else begin
      out_ready <= 1'b1;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic report_mismatch(input string what, input string exp_s, input string act_s);
    errors++;
    $display("FAILED %s %s: expected %s, actual %s", cur_test, what, exp_s, act_s);
  endtask

  task automatic check_len(input string what, input x86_pkg::len_t exp, input x86_pkg::len_t act);
    checks++;
    if (exp !== act) begin
      report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    end
  endtask

  task automatic check_eip(input string what, input x86_pkg::eip_t exp, input x86_pkg::eip_t act);
    checks++;
    if (exp !== act) begin
      report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_word(input string what, input x86_pkg::word_t exp,
                            input x86_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_byte(input string what, input x86_pkg::byte_t exp,
                            input x86_pkg::byte_t act);
    checks++;
    if (exp !== act) begin
      report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_seg(input string what, input x86_pkg::seg_t exp, input x86_pkg::seg_t act);
    checks++;
    if (exp !== act) begin
      report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
    end
  endtask

  task automatic compare_decoded(input decode_pipe_pkg::decoded_t e,
                                 input decode_pipe_pkg::decoded_t a);
    check_byte("opcode", e.opcode, a.opcode);
    check_byte("modrm", e.modrm, a.modrm);
    check_byte("sib", e.sib, a.sib);
    check_word("disp", e.disp, a.disp);
    check_word("imm", e.imm, a.imm);
    check_len("len", e.len, a.len);
    check_eip("eip", e.eip, a.eip);
    check_eip("eip_next", e.eip_next, a.eip_next);
    check_seg("seg", e.seg, a.seg);
    check_flag("esc", e.esc, a.esc);
    check_flag("modrm_pr", e.modrm_pr, a.modrm_pr);
    check_flag("sib_pr", e.sib_pr, a.sib_pr);
    check_flag("repne", e.repne, a.repne);
    check_flag("opsize16", e.opsize16, a.opsize16);
    check_flag("seg_over", e.seg_over, a.seg_over);
    check_flag("hlt", e.hlt, a.hlt);
    check_flag("iret", e.iret, a.iret);
    check_flag("illegal", e.illegal, a.illegal);
  endtask

  // Scoreboard pops on every output handshake and pushes on every input one
  always @(posedge clk) begin : scoreboard
    int unsigned lat;
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: decode_top gave a result with no instruction waiting for it", cur_test);
      end else begin
        lat = cycle - acc_q.pop_front();
        compare_decoded(exp_q.pop_front(), out_data);
        items++;
        if (lat_mode && lat != 3) begin
          report_mismatch("latency", "3", $sformatf("%0d", lat));
        end
      end
    end
    if (!rst && in_valid && in_ready) begin
      exp_q.push_back(decode_ref(in_data));
      acc_q.push_back(cycle);
    end
  end

  task automatic pad_window();
    for (int i = 0; i < 16; i++) begin
      win_buf[i] = x86_pkg::byte_t'($urandom);
    end
  endtask

  task automatic send_window();
    decode_pipe_pkg::fetch_t f;
    int                      t;
    f.window = win_buf;
    f.eip    = $urandom;
    in_valid <= 1'b1;
    in_data  <= f;
    t = 0;
    @(posedge clk);
    while (!in_ready && t < SEND_LIMIT) begin
      @(posedge clk);
      t++;
    end
    if (!in_ready) begin
      abort_run("timeout: in_ready stayed low while an instruction was offered");
    end else begin
      in_valid <= 1'b0;
    end
  endtask

  // Lead bytes start at byte 0 and the last one sits in lead[7:0]
  task automatic send_insn(input logic [127:0] lead, input int n);
    pad_window();
    for (int i = 0; i < n; i++) begin
      win_buf[i] = lead[8*(n-1-i) +: 8];
    end
    send_window();
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && t < DRAIN_LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("timeout: %0d expected results never came out", exp_q.size()));
    end else begin
      @(posedge clk);
    end
  endtask

  task automatic start_test(input string name);
    cur_test          = name;
    test_start_errors = errors;
    items             = 0;
  endtask

  task automatic finish_test();
    wait_drain();
    // Stray outputs after the drain
    repeat (4) @(posedge clk);
    tests++;
    $display("test %-16s %0d results, %0d errors", cur_test, items, errors - test_start_errors);
  endtask

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_flag("out_valid after reset", 1'b0, out_valid);
    check_flag("in_ready after reset", 1'b1, in_ready);
    // Items caught in the stages by the reset are gone
    exp_q.delete();
    acc_q.delete();
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_plain_opcodes();
    start_test("plain_opcodes");
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 10; i++) begin
        send_insn(PLAIN_OPS[i], 1);
      end
      for (int op = 'hB8; op <= 'hBF; op++) begin
        send_insn(op, 1);
      end
    end
    send_insn({8'hEB, 8'hF0}, 2);
    send_insn({8'hE8, 8'h00, 8'h10, 8'h00, 8'h80}, 5);
    finish_test();
  endtask

  task automatic run_modrm_forms();
    start_test("modrm_forms");
    for (int m = 0; m < 32; m++) begin
      for (int k = 0; k < 3; k++) begin
        pad_window();
        win_buf[0]      = MODRM_OPS[k];
        win_buf[1][7:6] = m[4:3];
        win_buf[1][2:0] = m[2:0];
        // SIB base 101 needs disp32 under mod 00
        if (k == 0) begin
          win_buf[2][2:0] = 3'b101;
        end
        send_window();
      end
    end
    repeat (60) begin
      pad_window();
      win_buf[0] = MODRM_OPS[$urandom % 3];
      send_window();
    end
    finish_test();
  endtask

  task automatic run_prefixes();
    int k;
    start_test("prefixes");
    send_insn({8'h66, 8'hB8, 8'h34, 8'h12}, 4);
    send_insn({8'h66, 8'h05, 8'hCD, 8'hAB}, 4);
    send_insn({8'h66, 8'hE8, 8'hFE, 8'hFF}, 4);
    send_insn({8'h66, 8'h83, 8'hC0, 8'h80}, 4);
    send_insn({8'hF2, 8'h90}, 2);
    send_insn({8'hF2, 8'h66, 8'h89, 8'h45, 8'hF8}, 5);
    send_insn({8'h2E, 8'h36, 8'h64, 8'h90}, 4);
    send_insn({8'h65, 8'h26, 8'h3E, 8'h2E, 8'hC3}, 5);
    send_insn({8'h66, 8'hF2, 8'h2E, 8'h64, 8'hB8}, 5);
    // Fifth prefix byte lands in the opcode slot
    send_insn({8'h66, 8'hF2, 8'h2E, 8'h64, 8'h65}, 5);
    repeat (40) begin
      pad_window();
      k = $urandom % 5;
      for (int i = 0; i < k; i++) begin
        win_buf[i] = PREFIX_BYTES[$urandom % 9];
      end
      win_buf[k] = ($urandom % 4 == 0) ? 8'hAF : PLAIN_OPS[$urandom % 10];
      send_window();
    end
    finish_test();
  endtask

  task automatic run_escape_special();
    start_test("escape_special");
    send_insn({8'h0F, 8'hAF, 8'hC1}, 3);
    send_insn({8'h0F, 8'hAF, 8'h44, 8'h24, 8'h08}, 5);
    send_insn(8'hF4, 1);
    send_insn(8'hCF, 1);
    send_insn({8'h0F, 8'hF4}, 2);
    send_insn(8'h00, 1);
    send_insn(8'hFF, 1);
    send_insn(8'hD6, 1);
    send_insn({8'h66, 8'hC7}, 2);
    send_insn({8'h0F, 8'h05}, 2);
    finish_test();
  endtask

  task automatic run_back_pressure();
    start_test("back_pressure");
    bp_mode <= 1'b1;
    repeat (300) begin
      pad_window();
      if ($urandom % 2 == 1) begin
        win_buf[0] = PLAIN_OPS[$urandom % 10];
      end
      send_window();
      repeat ($urandom % 3) @(posedge clk);
    end
    finish_test();
    bp_mode <= 1'b0;
  endtask

  task automatic run_reset_latency();
    start_test("reset_latency");
    // All three slots hold an item while the output is stalled
    stall_mode <= 1'b1;
    repeat (3) begin
      pad_window();
      send_window();
    end
    apply_reset();
    stall_mode <= 1'b0;
    lat_mode   <= 1'b1;
    repeat (24) begin
      pad_window();
      send_window();
    end
    finish_test();
    lat_mode <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h208c));
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    bp_mode    = 1'b0;
    stall_mode = 1'b0;
    lat_mode   = 1'b0;
    cycle      = 0;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    items      = 0;
    start_test("initial_reset");
    apply_reset();
    finish_test();
    run_plain_opcodes();
    run_modrm_forms();
    run_prefixes();
    run_escape_special();
    run_back_pressure();
    run_reset_latency();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* source/decode_top.sv */
//**********************************************************
// Three stage x86 decode pipeline
//**********************************************************
module decode_top #(
  parameter int WINDOW_BYTES = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  decode_pipe_pkg::fetch_t   in_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output decode_pipe_pkg::decoded_t out_data
);

  logic                     scan_valid;
  logic                     scan_ready;
  decode_pipe_pkg::scan_t   scan_data;
  logic                     fields_valid;
  logic                     fields_ready;
  decode_pipe_pkg::fields_t fields_data;

  prefix_scan #(.WINDOW_BYTES(WINDOW_BYTES)) i_prefix_scan (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (scan_valid),
    .out_ready (scan_ready),
    .out_data  (scan_data)
  );

  opcode_lookup #(.WINDOW_BYTES(WINDOW_BYTES)) i_opcode_lookup (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (scan_valid),
    .in_ready  (scan_ready),
    .in_data   (scan_data),
    .out_valid (fields_valid),
    .out_ready (fields_ready),
    .out_data  (fields_data)
  );

  length_calc #(.WINDOW_BYTES(WINDOW_BYTES)) i_length_calc (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (fields_valid),
    .in_ready  (fields_ready),
    .in_data   (fields_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

/* source/length_calc.sv */
//**********************************************************
// Stage 3 operand extraction, length and next EIP
//**********************************************************
module length_calc #(
  parameter int WINDOW_BYTES = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  decode_pipe_pkg::fields_t  in_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output decode_pipe_pkg::decoded_t out_data
);

  x86_pkg::byte_t [WINDOW_BYTES-1:0] win;
  int                                disp_ofs;
  int                                imm_ofs;
  x86_pkg::byte_t [3:0]              raw_disp;
  x86_pkg::byte_t [3:0]              raw_imm;
  x86_pkg::len_t                     len;
  decode_pipe_pkg::decoded_t         dec;

  // Byte values sign extend, word values zero extend
  function automatic x86_pkg::word_t extract(input x86_pkg::byte_t [3:0] b,
                                             input logic [2:0] n);
    case (n)
      3'd1:    return {{24{b[0][7]}}, b[0]};
      3'd2:    return {16'h0000, b[1], b[0]};
      3'd4:    return {b[3], b[2], b[1], b[0]};
      default: return 32'h0000_0000;
    endcase
  endfunction

  always_comb begin
    win = '0;
    win[decode_pipe_pkg::FETCH_BYTES-1:0] = in_data.scan.fetch.window;
  end

  always_comb begin
    disp_ofs = int'(in_data.scan.pfx.count) + 1 + int'(in_data.cls.has_modrm)
             + int'(in_data.sib_pr);
    imm_ofs  = disp_ofs + int'(in_data.disp_bytes);
    for (int k = 0; k < 4; k++) begin
      raw_disp[k] = win[disp_ofs+k];
      raw_imm[k]  = win[imm_ofs+k];
    end
  end

  // Illegal opcodes carry no operand fields, leaving count + 1
  assign len = {1'b0, in_data.scan.pfx.count} + 4'd1
             + {3'b000, in_data.cls.has_modrm} + {3'b000, in_data.sib_pr}
             + {1'b0, in_data.disp_bytes} + {1'b0, in_data.imm_bytes};

  always_comb begin
    dec.opcode   = in_data.opcode;
    dec.esc      = in_data.scan.pfx.esc;
    dec.modrm_pr = in_data.cls.has_modrm;
    dec.modrm    = in_data.modrm;
    dec.sib_pr   = in_data.sib_pr;
    dec.sib      = in_data.sib;
    dec.disp     = extract(raw_disp, in_data.disp_bytes);
    dec.imm      = extract(raw_imm, in_data.imm_bytes);
    dec.len      = len;
    dec.eip      = in_data.scan.fetch.eip;
    dec.eip_next = in_data.scan.fetch.eip + {28'h0000000, len};
    dec.repne    = in_data.scan.pfx.repne;
    dec.opsize16 = in_data.scan.pfx.opsize16;
    dec.seg_over = in_data.scan.pfx.seg_over;
    dec.seg      = in_data.scan.pfx.seg;
    dec.hlt      = !in_data.scan.pfx.esc && in_data.opcode == x86_pkg::OP_HLT;
    dec.iret     = !in_data.scan.pfx.esc && in_data.opcode == x86_pkg::OP_IRET;
    dec.illegal  = !in_data.cls.legal;
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= dec;
    end
  end

endmodule

/* source/opcode_lookup.sv */
//**********************************************************
// Stage 2 opcode, ModRM and SIB selection
//**********************************************************
module opcode_lookup #(
  parameter int WINDOW_BYTES = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  decode_pipe_pkg::scan_t   in_data,
  output logic                     out_valid,
  input  logic                     out_ready,
  output decode_pipe_pkg::fields_t out_data
);

  x86_pkg::byte_t [WINDOW_BYTES-1:0] win;
  int                                ofs;
  x86_pkg::byte_t                    opcode;
  x86_pkg::byte_t                    modrm_raw;
  x86_pkg::byte_t                    sib_raw;
  x86_pkg::op_class_t                cls;
  logic [1:0]                        mode;
  logic [2:0]                        rm;
  logic                              sib_pr;
  logic [2:0]                        disp_bytes;
  logic [2:0]                        imm_bytes;

  always_comb begin
    win = '0;
    win[decode_pipe_pkg::FETCH_BYTES-1:0] = in_data.fetch.window;
  end

  // Opcode sits right after the prefix run
  assign ofs       = int'(in_data.pfx.count);
  assign opcode    = win[ofs];
  assign modrm_raw = win[ofs+1];
  assign sib_raw   = win[ofs+2];

  assign cls  = x86_pkg::opcode_class(in_data.pfx.esc, opcode);
  assign mode = modrm_raw[7:6];
  assign rm   = modrm_raw[2:0];

  // 32-bit addressing forms only
  always_comb begin
    sib_pr     = 1'b0;
    disp_bytes = 3'd0;
    if (cls.has_modrm) begin
      sib_pr = (mode != 2'b11) && (rm == 3'b100);
      case (mode)
        2'b00: begin
          if (rm == 3'b101 || (sib_pr && sib_raw[2:0] == 3'b101)) begin
            disp_bytes = 3'd4;
          end
        end
        2'b01:   disp_bytes = 3'd1;
        2'b10:   disp_bytes = 3'd4;
        default: disp_bytes = 3'd0;
      endcase
    end
  end

  always_comb begin
    case (cls.imm_kind)
      x86_pkg::IMM_BYTE: imm_bytes = 3'd1;
      x86_pkg::IMM_FULL: imm_bytes = in_data.pfx.opsize16 ? 3'd2 : 3'd4;
      default:           imm_bytes = 3'd0;
    endcase
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Absent ModRM and SIB bytes are passed on as zero
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data.scan       <= in_data;
      out_data.opcode     <= opcode;
      out_data.modrm      <= cls.has_modrm ? modrm_raw : 8'h00;
      out_data.sib        <= sib_pr ? sib_raw : 8'h00;
      out_data.cls        <= cls;
      out_data.sib_pr     <= sib_pr;
      out_data.disp_bytes <= disp_bytes;
      out_data.imm_bytes  <= imm_bytes;
    end
  end

endmodule

/* source/prefix_scan.sv */
//**********************************************************
// Stage 1 prefix scanner and its register slot
//**********************************************************
module prefix_scan #(
  parameter int WINDOW_BYTES = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  decode_pipe_pkg::fetch_t in_data,
  output logic                    out_valid,
  input  logic                    out_ready,
  output decode_pipe_pkg::scan_t  out_data
);

  x86_pkg::byte_t [WINDOW_BYTES-1:0] win;
  decode_pipe_pkg::prefix_t          pfx;
  logic                              run;

  always_comb begin
    win = '0;
    win[decode_pipe_pkg::FETCH_BYTES-1:0] = in_data.window;
  end

  // Walk the leading run so the last segment override wins
  always_comb begin
    pfx = '0;
    run = 1'b1;
    for (int i = 0; i < x86_pkg::MAX_PREFIX; i++) begin
      if (run) begin
        case (win[i])
          x86_pkg::PFX_REPNE:  pfx.repne = 1'b1;
          x86_pkg::PFX_OPSIZE: pfx.opsize16 = 1'b1;
          x86_pkg::PFX_ESC:    pfx.esc = 1'b1;
          x86_pkg::PFX_ES: begin
            pfx.seg_over = 1'b1;
            pfx.seg      = x86_pkg::SEG_ES;
          end
          x86_pkg::PFX_CS: begin
            pfx.seg_over = 1'b1;
            pfx.seg      = x86_pkg::SEG_CS;
          end
          x86_pkg::PFX_SS: begin
            pfx.seg_over = 1'b1;
            pfx.seg      = x86_pkg::SEG_SS;
          end
          x86_pkg::PFX_DS: begin
            pfx.seg_over = 1'b1;
            pfx.seg      = x86_pkg::SEG_DS;
          end
          x86_pkg::PFX_FS: begin
            pfx.seg_over = 1'b1;
            pfx.seg      = x86_pkg::SEG_FS;
          end
          x86_pkg::PFX_GS: begin
            pfx.seg_over = 1'b1;
            pfx.seg      = x86_pkg::SEG_GS;
          end
          default: run = 1'b0;
        endcase
        if (run) begin
          pfx.count = pfx.count + 3'd1;
        end
      end
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data.fetch <= in_data;
      out_data.pfx   <= pfx;
    end
  end

endmodule

/* source/decode_pipe_pkg.sv */
//**********************************************************
// Payload structs passed between the decode stages
//**********************************************************
package decode_pipe_pkg;

  localparam int FETCH_BYTES = 16;

  typedef struct packed {
    x86_pkg::byte_t [FETCH_BYTES-1:0] window;
    x86_pkg::eip_t                    eip;
  } fetch_t;

  typedef struct packed {
    logic [2:0]    count;
    logic          repne;
    logic          opsize16;
    logic          esc;
    logic          seg_over;
    x86_pkg::seg_t seg;
  } prefix_t;

  typedef struct packed {
    fetch_t  fetch;
    prefix_t pfx;
  } scan_t;

  typedef struct packed {
    scan_t              scan;
    x86_pkg::byte_t     opcode;
    x86_pkg::byte_t     modrm;
    x86_pkg::byte_t     sib;
    x86_pkg::op_class_t cls;
    logic               sib_pr;
    logic [2:0]         disp_bytes;
    logic [2:0]         imm_bytes;
  } fields_t;

  typedef struct packed {
    x86_pkg::byte_t opcode;
    logic           esc;
    logic           modrm_pr;
    x86_pkg::byte_t modrm;
    logic           sib_pr;
    x86_pkg::byte_t sib;
    x86_pkg::word_t disp;
    x86_pkg::word_t imm;
    x86_pkg::len_t  len;
    x86_pkg::eip_t  eip;
    x86_pkg::eip_t  eip_next;
    logic           repne;
    logic           opsize16;
    logic           seg_over;
    x86_pkg::seg_t  seg;
    logic           hlt;
    logic           iret;
    logic           illegal;
  } decoded_t;

endpackage

/* source/x86_pkg.sv */
//**********************************************************
// x86 byte encodings, field typedefs and the opcode table
//**********************************************************
package x86_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] eip_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  len_t;
  typedef logic [2:0]  seg_t;

  localparam int MAX_PREFIX = 4;

  localparam seg_t SEG_ES = 3'd0;
  localparam seg_t SEG_CS = 3'd1;
  localparam seg_t SEG_SS = 3'd2;
  localparam seg_t SEG_DS = 3'd3;
  localparam seg_t SEG_FS = 3'd4;
  localparam seg_t SEG_GS = 3'd5;

  // Prefix bytes
  localparam byte_t PFX_REPNE  = 8'hF2;
  localparam byte_t PFX_CS     = 8'h2E;
  localparam byte_t PFX_SS     = 8'h36;
  localparam byte_t PFX_DS     = 8'h3E;
  localparam byte_t PFX_ES     = 8'h26;
  localparam byte_t PFX_FS     = 8'h64;
  localparam byte_t PFX_GS     = 8'h65;
  localparam byte_t PFX_OPSIZE = 8'h66;
  localparam byte_t PFX_ESC    = 8'h0F;

  localparam byte_t OP_HLT  = 8'hF4;
  localparam byte_t OP_IRET = 8'hCF;

  // Full means 4 bytes, or 2 under the 66 prefix
  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_BYTE,
    IMM_FULL
  } imm_kind_t;

  typedef struct packed {
    logic      legal;
    logic      has_modrm;
    imm_kind_t imm_kind;
  } op_class_t;

  function automatic op_class_t opcode_class(input logic esc, input byte_t op);
    op_class_t c;
    c = '{legal: 1'b0, has_modrm: 1'b0, imm_kind: IMM_NONE};
    if (esc) begin
      // imul r32, r/m32 is the only two-byte opcode
      if (op == 8'hAF) c = '{legal: 1'b1, has_modrm: 1'b1, imm_kind: IMM_NONE};
    end else begin
      case (op) inside
        8'h01, 8'h89:        c = '{legal: 1'b1, has_modrm: 1'b1, imm_kind: IMM_NONE};
        8'h83:               c = '{legal: 1'b1, has_modrm: 1'b1, imm_kind: IMM_BYTE};
        8'h05, [8'hB8:8'hBF]: c = '{legal: 1'b1, has_modrm: 1'b0, imm_kind: IMM_FULL};
        8'hE8:               c = '{legal: 1'b1, has_modrm: 1'b0, imm_kind: IMM_FULL};
        8'hEB:               c = '{legal: 1'b1, has_modrm: 1'b0, imm_kind: IMM_BYTE};
        8'h90, 8'hC3, OP_IRET, OP_HLT: c = '{legal: 1'b1, has_modrm: 1'b0, imm_kind: IMM_NONE};
        default:             c = '{legal: 1'b0, has_modrm: 1'b0, imm_kind: IMM_NONE};
      endcase
    end
    return c;
  endfunction

endpackage
